// ==== Makefile ====
# verilator build and run of the icache testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module tb_icache -o sim_icache

# the run passes only when the log holds the pass line
run: compile
	./obj_dir/sim_icache > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/icache_bus_pkg.sv ====
`default_nettype none

package icache_bus_pkg;

  // fetch address split for the cache lookup
  // tag on top, then index, word in line, byte in word
  typedef struct packed {
    logic [icache_cfg_pkg::TAG_W-1:0]   tag;
    logic [icache_cfg_pkg::INDEX_W-1:0] index;
    logic [icache_cfg_pkg::WORD_W-1:0]  word;
    logic [icache_cfg_pkg::BYTE_W-1:0]  byte_sel;
  } addr_fields_t;

  // cpu fetch request, one cycle per sample
  typedef struct packed {
    logic                            valid;
    logic [icache_cfg_pkg::XLEN-1:0] addr;
  } fetch_req_t;

  // fetch response, valid is a single cycle pulse
  typedef struct packed {
    logic                            valid;
    logic [icache_cfg_pkg::XLEN-1:0] data;
  } fetch_rsp_t;

  // memory read request
  // valid held until the last beat, len is beats minus one
  typedef struct packed {
    logic                             valid;
    logic [icache_cfg_pkg::XLEN-1:0]  addr;
    logic [icache_cfg_pkg::LEN_W-1:0] len;
  } mem_req_t;

  // one beat per cycle with valid high
  typedef struct packed {
    logic                            valid;
    logic [icache_cfg_pkg::XLEN-1:0] data;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== design/icache_cfg_pkg.sv ====
`default_nettype none

package icache_cfg_pkg;

  // fetch port and memory port width
  localparam int unsigned XLEN = 32;

  // 8 KB direct mapped
  // 128 lines of 64 bytes
  localparam int unsigned LINE_COUNT = 128;
  localparam int unsigned INDEX_W = 7;

  // sixteen 32-bit words per line
  localparam int unsigned WORDS_PER_LINE = 16;
  localparam int unsigned WORD_W = 4;

  // byte offset inside a word, ignored on fetch
  localparam int unsigned BYTE_W = 2;

  // whatever is left above index and offsets
  localparam int unsigned TAG_W = XLEN - INDEX_W - WORD_W - BYTE_W;

  // memory burst length field
  localparam int unsigned LEN_W = 8;

  // len is beats minus one, so 15 means a 16 beat refill
  localparam logic [LEN_W-1:0] BURST_LEN = 8'd15;

  // cacheable window
  // an address is cached when (addr & mask) == base
  localparam logic [XLEN-1:0] CACHED_BASE = 32'h8000_0000;
  localparam logic [XLEN-1:0] CACHED_MASK = 32'hf000_0000;

endpackage

`default_nettype wire

// ==== design/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  wire logic                              clk,
  input  wire logic                              rst,
  // cpu side
  input  wire icache_bus_pkg::fetch_req_t        fetch_req_i,
  output icache_bus_pkg::fetch_rsp_t             fetch_rsp_o,
  // memory side
  output icache_bus_pkg::mem_req_t               mem_req_o,
  input  wire icache_bus_pkg::mem_rsp_t          mem_rsp_i,
  // tag store
  input  wire logic                              hit_i,
  output icache_bus_pkg::addr_fields_t           lookup_o,
  // data store
  input  wire logic [icache_cfg_pkg::XLEN-1:0]   rdata_i,
  output logic                                   wr_en_o,
  output logic [icache_cfg_pkg::WORD_W-1:0]      wr_word_o,
  output logic [icache_cfg_pkg::XLEN-1:0]        wdata_o,
  output logic                                   tag_write_o
);

  typedef enum logic [2:0] {
    ST_RESET,
    ST_IDLE,
    ST_LOOKUP,
    ST_MISS,
    ST_UNCACHED
  } state_t;

  state_t state_q;

  // registered fetch address drives lookup and data read
  icache_bus_pkg::addr_fields_t addr_q;

  // memory request held for the whole burst
  icache_bus_pkg::mem_req_t mem_req_q;

  // beat counter doubles as refill word offset
  logic [icache_cfg_pkg::WORD_W-1:0] word_q;

  // uncached word and its one cycle response flag
  logic [icache_cfg_pkg::XLEN-1:0] unc_data_q;
  logic                            unc_valid_q;

  logic cacheable;
  logic beat;
  logic last_beat;
  logic lookup_hit;
  logic sample_req;

  // window check on the registered address
  assign cacheable = (addr_q & icache_cfg_pkg::CACHED_MASK) == icache_cfg_pkg::CACHED_BASE;

  // a beat moves whenever memory has data while we are asking
  assign beat = mem_req_q.valid && mem_rsp_i.valid;
  assign last_beat = word_q == icache_cfg_pkg::BURST_LEN[icache_cfg_pkg::WORD_W-1:0];

  // a hit only counts for a cacheable lookup
  assign lookup_hit = (state_q == ST_LOOKUP) && cacheable && hit_i;

  // fetch port only listens in idle or right behind a hit
  assign sample_req = fetch_req_i.valid && ((state_q == ST_IDLE) || lookup_hit);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= ST_RESET;
      mem_req_q.valid <= 1'b0;
      unc_valid_q     <= 1'b0;
      word_q          <= '0;
    end else begin
      // response flag lives for one cycle only
      unc_valid_q <= 1'b0;
      case (state_q)
        ST_RESET: begin
          // one spare cycle out of reset
          state_q <= ST_IDLE;
        end
        ST_IDLE: begin
          if (fetch_req_i.valid) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (!cacheable) begin
            // single word at the exact address
            state_q         <= ST_UNCACHED;
            mem_req_q.valid <= 1'b1;
            mem_req_q.addr  <= addr_q;
            mem_req_q.len   <= '0;
          end else if (!hit_i) begin
            // whole line from its base
            state_q         <= ST_MISS;
            mem_req_q.valid <= 1'b1;
            mem_req_q.addr  <= {addr_q.tag, addr_q.index, {icache_cfg_pkg::WORD_W{1'b0}},
                                {icache_cfg_pkg::BYTE_W{1'b0}}};
            mem_req_q.len   <= icache_cfg_pkg::BURST_LEN;
            word_q          <= '0;
          end else if (!fetch_req_i.valid) begin
            // hit with nothing behind it
            state_q <= ST_IDLE;
          end
        end
        ST_MISS: begin
          if (beat) begin
            word_q <= word_q + icache_cfg_pkg::WORD_W'(1);
            if (last_beat) begin
              // tag goes in on this same edge
              mem_req_q.valid <= 1'b0;
              state_q         <= ST_IDLE;
            end
          end
        end
        ST_UNCACHED: begin
          if (beat) begin
            mem_req_q.valid <= 1'b0;
            unc_valid_q     <= 1'b1;
            state_q         <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // fetch address and uncached data word
  always_ff @(posedge clk) begin
    if (sample_req) begin
      addr_q <= fetch_req_i.addr;
    end
    if ((state_q == ST_UNCACHED) && beat) begin
      unc_data_q <= mem_rsp_i.data;
    end
  end

  assign lookup_o  = addr_q;
  assign mem_req_o = mem_req_q;

  // refill writes straight from the memory beat
  assign wr_en_o     = (state_q == ST_MISS) && beat;
  assign wr_word_o   = word_q;
  assign wdata_o     = mem_rsp_i.data;
  assign tag_write_o = (state_q == ST_MISS) && beat && last_beat;

  // uncached word wins in the idle cycle after its beat
  assign fetch_rsp_o.valid = lookup_hit || unc_valid_q;
  assign fetch_rsp_o.data  = unc_valid_q ? unc_data_q : rdata_i;

endmodule

`default_nettype wire

// ==== design/icache_data_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_data_store (
  input  wire logic                               clk,
  // read side, addressed by the registered fetch address
  input  wire logic [icache_cfg_pkg::INDEX_W-1:0] rd_index_i,
  input  wire logic [icache_cfg_pkg::WORD_W-1:0]  rd_word_i,
  output logic [icache_cfg_pkg::XLEN-1:0]         rdata_o,
  // refill side, one word per memory beat
  input  wire logic                               wr_en_i,
  input  wire logic [icache_cfg_pkg::INDEX_W-1:0] wr_index_i,
  input  wire logic [icache_cfg_pkg::WORD_W-1:0]  wr_word_i,
  input  wire logic [icache_cfg_pkg::XLEN-1:0]    wdata_i
);

  // line data, LINE_COUNT lines of WORDS_PER_LINE words
  logic [icache_cfg_pkg::XLEN-1:0] mem_q
    [icache_cfg_pkg::LINE_COUNT][icache_cfg_pkg::WORDS_PER_LINE];

  // burst write
  // word offset walks 0..15 over the refill
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_index_i][wr_word_i] <= wdata_i;
    end
  end

  // asynchronous read so a hit answers in the lookup cycle
  assign rdata_o = mem_q[rd_index_i][rd_word_i];

endmodule

`default_nettype wire

// ==== design/icache_tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store (
  input  wire logic                               clk,
  input  wire logic                               rst,
  input  wire logic [icache_cfg_pkg::INDEX_W-1:0] index_i,
  input  wire logic [icache_cfg_pkg::TAG_W-1:0]   tag_i,
  input  wire logic                               write_i,
  output logic                                    hit_o
);

  // one valid bit per line
  logic [icache_cfg_pkg::LINE_COUNT-1:0] valid_q;

  // tag per line, only meaningful once the valid bit is set
  logic [icache_cfg_pkg::TAG_W-1:0] tag_q [icache_cfg_pkg::LINE_COUNT];

  // valid bits come up cleared so the cache starts cold
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (write_i) begin
      // line filled, mark it usable
      valid_q[index_i] <= 1'b1;
    end
  end

  // tag captured in the same cycle the valid bit goes up
  always_ff @(posedge clk) begin
    if (write_i) begin
      tag_q[index_i] <= tag_i;
    end
  end

  // combinational compare on the indexed line
  // a tag written this cycle is seen from the next edge on
  assign hit_o = valid_q[index_i] && (tag_q[index_i] == tag_i);

endmodule

`default_nettype wire

// ==== design/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire logic                     clk,
  input  wire logic                     rst,
  // cpu fetch port
  input  wire icache_bus_pkg::fetch_req_t fetch_req_i,
  output icache_bus_pkg::fetch_rsp_t      fetch_rsp_o,
  // memory read port
  output icache_bus_pkg::mem_req_t        mem_req_o,
  input  wire icache_bus_pkg::mem_rsp_t   mem_rsp_i
);

  // registered fetch address split into fields
  icache_bus_pkg::addr_fields_t lookup;

  logic                              hit;
  logic                              tag_write;
  logic [icache_cfg_pkg::XLEN-1:0]   rdata;
  logic                              wr_en;
  logic [icache_cfg_pkg::WORD_W-1:0] wr_word;
  logic [icache_cfg_pkg::XLEN-1:0]   wdata;

  icache_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req_i),
    .fetch_rsp_o (fetch_rsp_o),
    .mem_req_o   (mem_req_o),
    .mem_rsp_i   (mem_rsp_i),
    .hit_i       (hit),
    .lookup_o    (lookup),
    .rdata_i     (rdata),
    .wr_en_o     (wr_en),
    .wr_word_o   (wr_word),
    .wdata_o     (wdata),
    .tag_write_o (tag_write)
  );

  icache_tag_store u_tag (
    .clk     (clk),
    .rst     (rst),
    .index_i (lookup.index),
    .tag_i   (lookup.tag),
    .write_i (tag_write),
    .hit_o   (hit)
  );

  // refill lands on the line of the held address
  icache_data_store u_data (
    .clk        (clk),
    .rd_index_i (lookup.index),
    .rd_word_i  (lookup.word),
    .rdata_o    (rdata),
    .wr_en_i    (wr_en),
    .wr_index_i (lookup.index),
    .wr_word_i  (wr_word),
    .wdata_i    (wdata)
  );

endmodule

`default_nettype wire

// ==== dv/tb_icache_tasks.svh ====
`ifndef TB_ICACHE_TASKS_SVH
`define TB_ICACHE_TASKS_SVH

  task automatic check_rsp(input string name, input icache_bus_pkg::fetch_rsp_t got, exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_mem_req(input string name, input icache_bus_pkg::mem_req_t got, exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic idle_after_reset();
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_bit("mem_req_o.valid", mem_req.valid, 1'b0);
      check_bit("fetch_rsp_o.valid", fetch_rsp.valid, 1'b0);
    end
  endtask

  // one request cycle then back to the lookup cycle
  task automatic present_fetch(input logic [31:0] addr);
    fetch_req.valid = 1'b1;
    fetch_req.addr = addr;
    @(negedge clk);
    fetch_req.valid = 1'b0;
  endtask

  // hit answers in the lookup cycle
  task automatic fetch_hit(input logic [31:0] addr);
    present_fetch(addr);
    check_rsp("fetch_rsp_o", fetch_rsp, icache_bus_pkg::fetch_rsp_t'({1'b1, memory_word(addr)}));
    check_bit("mem_req_o.valid", mem_req.valid, 1'b0);
    @(negedge clk);
  endtask

  // miss gives one 16 beat burst from the 64 byte line base
  task automatic refill_line(input logic [31:0] addr);
    int reqs;
    int beats;
    int n;
    reqs = req_count;
    beats = beat_count;
    n = 0;
    present_fetch(addr);
    check_bit("fetch_rsp_o.valid", fetch_rsp.valid, 1'b0);
    check_bit("mem_req_o.valid", mem_req.valid, 1'b0);
    @(negedge clk);
    check_mem_req("mem_req_o", mem_req,
                  icache_bus_pkg::mem_req_t'({1'b1, (addr & ~32'h3f), 8'd15}));
    // no fetch response while the line fills
    while (mem_req.valid && n < WAIT_LIMIT) begin
      check_bit("fetch_rsp_o.valid", fetch_rsp.valid, 1'b0);
      @(negedge clk);
      n++;
    end
    if (mem_req.valid) begin
      abort_run($sformatf("refill of %h did not finish within %0d cycles", addr, WAIT_LIMIT));
    end else if (req_count != reqs + 1 || beat_count != beats + 16) begin
      abort_run($sformatf("refill of %h used %0d requests and %0d beats instead of 1 and 16",
                          addr, req_count - reqs, beat_count - beats));
    end
  endtask

  // sixteen hits on consecutive cycles
  task automatic sweep_line(input logic [31:0] base);
    fetch_req.valid = 1'b1;
    fetch_req.addr = base;
    for (int k = 1; k <= 16; k++) begin
      @(negedge clk);
      check_rsp("fetch_rsp_o", fetch_rsp,
                icache_bus_pkg::fetch_rsp_t'({1'b1, memory_word(base + 32'((k - 1) * 4))}));
      check_bit("mem_req_o.valid", mem_req.valid, 1'b0);
      fetch_req.addr = base + 32'(k * 4);
    end
    fetch_req.valid = 1'b0;
    @(negedge clk);
    check_bit("fetch_rsp_o.valid", fetch_rsp.valid, 1'b0);
  endtask

  // exact address with len 0 and one response pulse
  task automatic fetch_uncached(input logic [31:0] addr);
    int reqs;
    int n;
    reqs = req_count;
    n = 0;
    present_fetch(addr);
    check_bit("fetch_rsp_o.valid", fetch_rsp.valid, 1'b0);
    @(negedge clk);
    check_mem_req("mem_req_o", mem_req, icache_bus_pkg::mem_req_t'({1'b1, addr, 8'd0}));
    while (!fetch_rsp.valid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!fetch_rsp.valid) begin
      abort_run($sformatf("no response to the uncached fetch of %h", addr));
    end else begin
      check_rsp("fetch_rsp_o", fetch_rsp, icache_bus_pkg::fetch_rsp_t'({1'b1, memory_word(addr)}));
      check_bit("mem_req_o.valid", mem_req.valid, 1'b0);
      @(negedge clk);
      check_bit("fetch_rsp_o.valid", fetch_rsp.valid, 1'b0);
      if (req_count != reqs + 1) begin
        abort_run($sformatf("uncached fetch of %h made %0d memory requests instead of 1",
                            addr, req_count - reqs));
      end
    end
  endtask

`endif

// ==== dv/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  // upper bound on any single wait in cycles
  localparam int WAIT_LIMIT = 200;

  logic clk;
  logic rst;
  icache_bus_pkg::fetch_req_t fetch_req;
  icache_bus_pkg::fetch_rsp_t fetch_rsp;
  icache_bus_pkg::mem_req_t   mem_req;
  icache_bus_pkg::mem_rsp_t   mem_rsp;

  // memory model state
  logic [31:0] lfsr_q;
  logic [31:0] burst_addr;
  logic        busy;
  int          burst_len;
  int          beat_idx;
  int          gap;
  // requests and beats served so far
  int          req_count;
  int          beat_count;

  icache_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req),
    .fetch_rsp_o (fetch_rsp),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // word address xor a fixed pattern
  function automatic logic [31:0] memory_word(input logic [31:0] addr);
    return {2'b00, addr[31:2]} ^ 32'h5a5a_0000;
  endfunction

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // idle cycles before a beat
  // one lfsr step per bit taken
  task automatic draw_gap(output int cycles);
    logic [1:0] bits;
    for (int i = 0; i < 2; i++) begin
      bits = {bits[0], lfsr_q[31]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    cycles = int'(bits);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_icache_tasks.svh"

  // memory responder
  // a request is picked up on the first falling edge that shows it
  initial begin
    mem_rsp = '0;
    lfsr_q = 32'hbbf6_bb88;
    busy = 1'b0;
    req_count = 0;
    beat_count = 0;
    forever begin
      @(negedge clk);
      mem_rsp = '0;
      if (rst || !mem_req.valid) begin
        busy = 1'b0;
      end else begin
        if (!busy) begin
          busy = 1'b1;
          burst_addr = mem_req.addr;
          burst_len = int'(mem_req.len);
          beat_idx = 0;
          req_count++;
          draw_gap(gap);
        end
        // len plus one beats then silence until valid drops
        if (beat_idx <= burst_len) begin
          if (gap > 0) begin
            gap--;
          end else begin
            mem_rsp.valid = 1'b1;
            mem_rsp.data = memory_word(burst_addr + 32'(beat_idx * 4));
            beat_idx++;
            beat_count++;
            draw_gap(gap);
          end
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    fetch_req = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // ports stay quiet after reset
    idle_after_reset();
    // cold miss then the same address hits
    refill_line(32'h8000_1248);
    fetch_hit(32'h8000_1248);
    // whole line back to back
    sweep_line(32'h8000_1240);
    // other tag on index 0x49 evicts the first line
    refill_line(32'h8000_3248);
    fetch_hit(32'h8000_3248);
    refill_line(32'h8000_1248);
    fetch_hit(32'h8000_1248);
    // outside the window and never cached
    fetch_uncached(32'h0000_1a34);
    fetch_uncached(32'h0000_1a34);
    // refill with random beat gaps then read it all back
    refill_line(32'h8765_4fc4);
    sweep_line(32'h8765_4fc0);

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+dv
design/icache_cfg_pkg.sv
design/icache_bus_pkg.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache_ctrl.sv
design/icache_top.sv
dv/tb_icache.sv
